/* source/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath geometry
`define XLEN    32
`define REG_NUM 32
`define REG_AW  5

// 3R format, bits [31:15]
`define OP_ADD_W 17'h00020
`define OP_SUB_W 17'h00022
`define OP_SLT   17'h00024
`define OP_AND   17'h00029
`define OP_OR    17'h0002A
`define OP_XOR   17'h0002B

`define OP_ADDI_W  10'h00A  // 2RI12 format, bits [31:22]
`define OP_LU12I_W 7'h0A    // 1RI20 format, bits [31:25]

`endif

/* source/core_pkg.sv */
`include "core_params.svh"

package core_pkg;

    // Register to register, ADD.W and friends
    typedef struct packed {
        logic [16:0]         opcode;
        logic [`REG_AW-1:0]  rk;
        logic [`REG_AW-1:0]  rj;
        logic [`REG_AW-1:0]  rd;
    } fmt_3r_t;

    // Register plus 12-bit signed immediate
    typedef struct packed {
        logic [9:0]          opcode;
        logic [11:0]         si12;
        logic [`REG_AW-1:0]  rj;
        logic [`REG_AW-1:0]  rd;
    } fmt_2ri12_t;

    // Destination plus 20-bit immediate
    typedef struct packed {
        logic [6:0]          opcode;
        logic [19:0]         si20;
        logic [`REG_AW-1:0]  rd;
    } fmt_1ri20_t;

    // One instruction word, three decode views
    typedef union packed {
        fmt_3r_t     r3;
        fmt_2ri12_t  ri12;
        fmt_1ri20_t  ri20;
        logic [31:0] raw;
    } instr_word_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI  // Immediate passes straight through
    } alu_op_e;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        instr_word_u      instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        alu_op_e            alu_op;
        logic [`REG_AW-1:0] rd;
        logic [`REG_AW-1:0] rj;
        logic [`REG_AW-1:0] rk;
        logic [`XLEN-1:0]   imm;
        logic               use_imm;  // Second operand is imm, not rk
        logic               wen;
    } dec_op_t;

    // Shared by execute register, commit port and register write
    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic               wen;
        logic [`REG_AW-1:0] wnum;
        logic [`XLEN-1:0]   wdata;
    } commit_t;

endpackage

/* source/instr_decode.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module instr_decode (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 instr_valid_i,
    input  core_pkg::fetch_pkt_t instr_i,
    output logic                 instr_ready_o,
    input  logic                 hold_i,
    output logic                 dec_valid_o,
    output core_pkg::dec_op_t    dec_o
);

    core_pkg::instr_word_u word;
    core_pkg::dec_op_t     dec_d;
    logic                  legal;

    assign word          = instr_i.instr;
    assign instr_ready_o = ~hold_i;  // Whole pipeline moves as one

    always_comb begin
        dec_d        = '0;
        dec_d.pc     = instr_i.pc;
        dec_d.alu_op = core_pkg::ALU_ADD;
        legal        = 1'b1;
        if (word.ri20.opcode == `OP_LU12I_W) begin
            dec_d.alu_op  = core_pkg::ALU_LUI;
            dec_d.rd      = word.ri20.rd;
            dec_d.imm     = {word.ri20.si20, 12'b0};
            dec_d.use_imm = 1'b1;
        end else if (word.ri12.opcode == `OP_ADDI_W) begin
            dec_d.alu_op  = core_pkg::ALU_ADD;
            dec_d.rd      = word.ri12.rd;
            dec_d.rj      = word.ri12.rj;
            dec_d.imm     = {{20{word.ri12.si12[11]}}, word.ri12.si12};
            dec_d.use_imm = 1'b1;
        end else begin
            dec_d.rd = word.r3.rd;
            dec_d.rj = word.r3.rj;
            dec_d.rk = word.r3.rk;
            case (word.r3.opcode)
                `OP_ADD_W: dec_d.alu_op = core_pkg::ALU_ADD;
                `OP_SUB_W: dec_d.alu_op = core_pkg::ALU_SUB;
                `OP_SLT:   dec_d.alu_op = core_pkg::ALU_SLT;
                `OP_AND:   dec_d.alu_op = core_pkg::ALU_AND;
                `OP_OR:    dec_d.alu_op = core_pkg::ALU_OR;
                `OP_XOR:   dec_d.alu_op = core_pkg::ALU_XOR;
                default:   legal = 1'b0;
            endcase
        end

        // Illegal word turns into a zero result aimed at r0
        if (!legal) begin
            dec_d.alu_op  = core_pkg::ALU_LUI;
            dec_d.rd      = '0;
            dec_d.rj      = '0;
            dec_d.rk      = '0;
            dec_d.imm     = '0;
            dec_d.use_imm = 1'b1;
        end

        dec_d.wen = legal && (dec_d.rd != '0);  // r0 stays zero
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_valid_o <= 1'b0;
        end else if (!hold_i) begin
            dec_valid_o <= instr_valid_i;  // Ready is high here, so valid means accepted
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            dec_o <= dec_d;
        end
    end

    // Source must keep the packet until it is taken
    a_instr_stable: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        instr_valid_i && !instr_ready_o |=> instr_valid_i && $stable(instr_i)
    ) else $error("instr_i changed while held back");

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic [`REG_AW-1:0]   rd_addr_a_i,
    input  logic [`REG_AW-1:0]   rd_addr_b_i,
    output logic [`XLEN-1:0]     rd_data_a_o,
    output logic [`XLEN-1:0]     rd_data_b_o,
    input  logic                 wr_valid_i,
    input  core_pkg::commit_t    wr_i
);

    logic [`XLEN-1:0] regs [`REG_NUM];

    // r0 reads as zero whatever the array holds
    assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 : regs[rd_addr_a_i];
    assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 : regs[rd_addr_b_i];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_valid_i && wr_i.wen && (wr_i.wnum != '0)) begin
            regs[wr_i.wnum] <= wr_i.wdata;
        end
    end

    // Decode already strips r0 writes
    a_no_r0_write: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        wr_valid_i && wr_i.wen |-> wr_i.wnum != '0
    ) else $error("valid register write aimed at r0");

endmodule

/* source/alu_execute.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module alu_execute (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 dec_valid_i,
    input  core_pkg::dec_op_t    dec_i,
    input  logic                 hold_i,
    output logic [`REG_AW-1:0]   rf_addr_a_o,
    output logic [`REG_AW-1:0]   rf_addr_b_o,
    input  logic [`XLEN-1:0]     rf_data_a_i,
    input  logic [`XLEN-1:0]     rf_data_b_i,
    output logic                 exe_valid_o,
    output core_pkg::commit_t    exe_o
);

    logic              fwd_a;
    logic              fwd_b;
    logic [`XLEN-1:0]  src_a;
    logic [`XLEN-1:0]  src_b;
    logic [`XLEN-1:0]  op_b;
    logic [`XLEN-1:0]  result;
    core_pkg::commit_t exe_d;

    assign rf_addr_a_o = dec_i.rj;
    assign rf_addr_b_o = dec_i.rk;

    // Only the execute register can be newer than the register file
    assign fwd_a = exe_valid_o && exe_o.wen && (exe_o.wnum == dec_i.rj);
    assign fwd_b = exe_valid_o && exe_o.wen && (exe_o.wnum == dec_i.rk);

    assign src_a = fwd_a ? exe_o.wdata : rf_data_a_i;
    assign src_b = fwd_b ? exe_o.wdata : rf_data_b_i;
    assign op_b  = dec_i.use_imm ? dec_i.imm : src_b;

    always_comb begin
        case (dec_i.alu_op)
            core_pkg::ALU_ADD: result = src_a + op_b;
            core_pkg::ALU_SUB: result = src_a - op_b;  // Wraps at 32 bits
            core_pkg::ALU_SLT: result = {{(`XLEN-1){1'b0}}, $signed(src_a) < $signed(op_b)};
            core_pkg::ALU_AND: result = src_a & op_b;
            core_pkg::ALU_OR:  result = src_a | op_b;
            core_pkg::ALU_XOR: result = src_a ^ op_b;
            core_pkg::ALU_LUI: result = op_b;
            default:           result = '0;
        endcase
    end

    always_comb begin
        exe_d.pc    = dec_i.pc;
        exe_d.wen   = dec_i.wen;
        exe_d.wnum  = dec_i.rd;
        exe_d.wdata = result;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exe_valid_o <= 1'b0;
        end else if (!hold_i) begin
            exe_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            exe_o <= exe_d;
        end
    end

    // Decode never emits an unused op code
    a_alu_op_defined: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        dec_valid_i |-> dec_i.alu_op inside {core_pkg::ALU_ADD, core_pkg::ALU_SUB,
                                             core_pkg::ALU_SLT, core_pkg::ALU_AND,
                                             core_pkg::ALU_OR,  core_pkg::ALU_XOR,
                                             core_pkg::ALU_LUI}
    ) else $error("undefined alu_op on a valid entry");

endmodule

/* source/commit_result.sv */
`timescale 1ns/1ps

module commit_result (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              exe_valid_i,
    input  core_pkg::commit_t exe_i,
    input  logic              commit_ready_i,
    output logic              commit_valid_o,
    output core_pkg::commit_t commit_o,
    output logic              hold_o,
    output logic              rf_wr_valid_o,
    output core_pkg::commit_t rf_wr_o
);

    // Stalled commit freezes every stage behind it
    assign hold_o = commit_valid_o & ~commit_ready_i;

    // Write lands on the same edge the entry moves into commit
    assign rf_wr_valid_o = exe_valid_i & ~hold_o;
    assign rf_wr_o       = exe_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            commit_valid_o <= 1'b0;
        end else if (!hold_o) begin
            commit_valid_o <= exe_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_o) begin
            commit_o <= exe_i;
        end
    end

    // Trace entry and the execute entry behind it stay put until the sink takes it
    a_commit_stable: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        commit_valid_o && !commit_ready_i |=>
            commit_valid_o && $stable(commit_o) && $stable(exe_valid_i) && $stable(exe_i)
    ) else $error("commit_o or the execute entry changed while held");

endmodule

/* source/core_top.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module core_top (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 instr_valid_i,
    input  core_pkg::fetch_pkt_t instr_i,
    output logic                 instr_ready_o,
    output logic                 commit_valid_o,
    output core_pkg::commit_t    commit_o,
    input  logic                 commit_ready_i
);

    logic               hold;
    logic               dec_valid;
    core_pkg::dec_op_t  dec;
    logic               exe_valid;
    core_pkg::commit_t  exe;
    logic [`REG_AW-1:0] rf_addr_a;
    logic [`REG_AW-1:0] rf_addr_b;
    logic [`XLEN-1:0]   rf_data_a;
    logic [`XLEN-1:0]   rf_data_b;
    logic               rf_wr_valid;
    core_pkg::commit_t  rf_wr;

    instr_decode u_instr_decode (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_ready_o (instr_ready_o),
        .hold_i        (hold),
        .dec_valid_o   (dec_valid),
        .dec_o         (dec)
    );

    reg_file u_reg_file (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .rd_addr_a_i (rf_addr_a),
        .rd_addr_b_i (rf_addr_b),
        .rd_data_a_o (rf_data_a),
        .rd_data_b_o (rf_data_b),
        .wr_valid_i  (rf_wr_valid),
        .wr_i        (rf_wr)
    );

    alu_execute u_alu_execute (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .dec_valid_i (dec_valid),
        .dec_i       (dec),
        .hold_i      (hold),
        .rf_addr_a_o (rf_addr_a),
        .rf_addr_b_o (rf_addr_b),
        .rf_data_a_i (rf_data_a),
        .rf_data_b_i (rf_data_b),
        .exe_valid_o (exe_valid),
        .exe_o       (exe)
    );

    commit_result u_commit_result (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .exe_valid_i    (exe_valid),
        .exe_i          (exe),
        .commit_ready_i (commit_ready_i),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o),
        .hold_o         (hold),
        .rf_wr_valid_o  (rf_wr_valid),
        .rf_wr_o        (rf_wr)
    );

endmodule

/* tb/core_tb.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module core_tb;

    localparam int PROG_LEN       = 300;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 8 + 100;

    logic                 clk;
    logic                 arst_n_i;
    logic                 instr_valid_i;
    core_pkg::fetch_pkt_t instr_i;
    logic                 instr_ready_o;
    logic                 commit_valid_o;
    core_pkg::commit_t    commit_o;
    logic                 commit_ready_i;

    core_pkg::fetch_pkt_t prog [PROG_LEN];
    core_pkg::commit_t    exp_q [$];
    logic [`XLEN-1:0]     model_regs [`REG_NUM];
    logic [31:0]          rng_state = 32'h1fd6_db29;

    int                   cycle = 0;
    int                   n_accepted = 0;
    int                   n_committed = 0;
    int                   sent = 0;
    int                   acc_cycle;
    logic                 held_prev = 1'b0;
    core_pkg::commit_t    held_entry;
    core_pkg::commit_t    ent;

    core_top DUT (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .instr_ready_o  (instr_ready_o),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o),
        .commit_ready_i (commit_ready_i)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Small register set so results get reused soon
    function automatic logic [`REG_AW-1:0] pick_reg();
        return 5'(next_rand() % 6);
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0]        sel;
        logic [31:0]        imm;
        logic [`REG_AW-1:0] rd;
        logic [`REG_AW-1:0] rj;
        logic [`REG_AW-1:0] rk;
        logic [16:0]        op3;
        logic [31:0]        word;
        sel = next_rand() % 16;
        imm = next_rand();
        rd  = pick_reg();
        rj  = pick_reg();
        rk  = pick_reg();
        case (next_rand() % 6)
            0:       op3 = `OP_ADD_W;
            1:       op3 = `OP_SUB_W;
            2:       op3 = `OP_SLT;
            3:       op3 = `OP_AND;
            4:       op3 = `OP_OR;
            default: op3 = `OP_XOR;
        endcase
        if (sel == 0) begin
            word = next_rand() | 32'h8000_0000;  // No kept opcode has bit 31 set
        end else if (sel < 3) begin
            word = {`OP_LU12I_W, imm[19:0], rd};
        end else if (sel < 6) begin
            word = {`OP_ADDI_W, imm[11:0], rj, rd};
        end else begin
            word = {op3, rk, rj, rd};
        end
        return word;
    endfunction

    // Architectural result of one instruction, in program order
    function automatic core_pkg::commit_t predict_commit(core_pkg::fetch_pkt_t pkt);
        logic [31:0]        w;
        logic [`XLEN-1:0]   a;
        logic [`XLEN-1:0]   b;
        logic [`XLEN-1:0]   res;
        logic [`REG_AW-1:0] rd;
        logic               legal;
        core_pkg::commit_t  pred;
        w     = pkt.instr.raw;
        rd    = w[4:0];
        a     = model_regs[w[9:5]];
        b     = model_regs[w[14:10]];
        legal = 1'b1;
        res   = '0;
        if (w[31:25] == `OP_LU12I_W) begin
            res = {w[24:5], 12'h000};
        end else if (w[31:22] == `OP_ADDI_W) begin
            res = a + {{20{w[21]}}, w[21:10]};
        end else begin
            case (w[31:15])
                `OP_ADD_W: res = a + b;
                `OP_SUB_W: res = a - b;
                `OP_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                `OP_AND:   res = a & b;
                `OP_OR:    res = a | b;
                `OP_XOR:   res = a ^ b;
                default:   legal = 1'b0;
            endcase
        end
        if (!legal) begin
            rd  = '0;
            res = '0;
        end
        pred.pc    = pkt.pc;
        pred.wen   = legal && (rd != '0);
        pred.wnum  = rd;
        pred.wdata = res;
        if (pred.wen) begin
            model_regs[rd] = res;  // r0 is never written
        end
        return pred;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Error: %s is %h, expected %h", name, got, want);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: commits stopped arriving, %0d of %0d seen",
                     n_committed, PROG_LEN);
            $display("Errors found");
            $fatal(1);
        end
    end

    // Accepted instructions feed the reference model
    always @(posedge clk) begin
        if (arst_n_i && instr_valid_i && instr_ready_o) begin
            exp_q.push_back(predict_commit(instr_i));
            n_accepted++;
        end
    end

    always @(posedge clk) begin
        if (arst_n_i) begin
            if (held_prev) begin
                check_value("commit_valid_o", 32'(commit_valid_o), 32'd1);
                check_value("commit_o.pc", commit_o.pc, held_entry.pc);
                check_value("commit_o.wen", 32'(commit_o.wen), 32'(held_entry.wen));
                check_value("commit_o.wnum", 32'(commit_o.wnum), 32'(held_entry.wnum));
                check_value("commit_o.wdata", commit_o.wdata, held_entry.wdata);
            end
            if (commit_valid_o && commit_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("A commit arrived with no instruction outstanding");
                    $display("Errors found");
                    $fatal(1);
                end
                ent = exp_q.pop_front();
                check_value("commit_o.pc", commit_o.pc, ent.pc);
                check_value("commit_o.wen", 32'(commit_o.wen), 32'(ent.wen));
                check_value("commit_o.wnum", 32'(commit_o.wnum), 32'(ent.wnum));
                check_value("commit_o.wdata", commit_o.wdata, ent.wdata);
                n_committed++;
            end
            held_prev  = commit_valid_o && !commit_ready_i;
            held_entry = commit_o;
        end
    end

    initial begin
        arst_n_i       = 1'b0;
        instr_valid_i  = 1'b0;
        instr_i        = '0;
        commit_ready_i = 1'b0;
        for (int i = 0; i < `REG_NUM; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i].pc        = 32'h1c00_0000 + 32'(i) * 4;
            prog[i].instr.raw = random_word();
        end

        repeat (5) @(negedge clk);
        arst_n_i = 1'b1;
        check_value("commit_valid_o", 32'(commit_valid_o), 32'd0);
        check_value("instr_ready_o", 32'(instr_ready_o), 32'd1);

        // Lone instruction with the sink always ready
        @(negedge clk);
        commit_ready_i = 1'b1;
        instr_i        = prog[0];
        instr_valid_i  = 1'b1;
        sent           = 1;
        @(negedge clk);
        acc_cycle     = cycle;
        instr_valid_i = 1'b0;
        check_value("n_accepted", 32'(n_accepted), 32'd1);
        while (n_committed == 0) begin  // Edge of the commit transfer
            @(negedge clk);
        end
        check_value("commit latency", 32'(cycle - acc_cycle), 32'd3);

        // Random valid and back-pressure
        while (n_accepted < PROG_LEN) begin
            @(negedge clk);
            commit_ready_i = (next_rand() % 4) != 0;
            if (!(instr_valid_i && n_accepted < sent)) begin
                if (sent < PROG_LEN && (next_rand() % 4) != 0) begin
                    instr_i       = prog[sent];
                    instr_valid_i = 1'b1;
                    sent++;
                end else begin
                    instr_valid_i = 1'b0;
                end
            end
        end

        while (n_committed < PROG_LEN) begin
            @(negedge clk);
            commit_ready_i = (next_rand() % 4) != 0;
        end
        commit_ready_i = 1'b1;
        repeat (4) @(negedge clk);  // Any extra commit trips the compare

        if (exp_q.size() == 0 && n_committed == PROG_LEN) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "expected commits were left over at the end");
        end
    end

endmodule

/* vlog.f */
+incdir+source
source/core_pkg.sv
source/instr_decode.sv
source/reg_file.sv
source/alu_execute.sv
source/commit_result.sv
source/core_top.sv
tb/core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module core_tb -f vlog.f -o core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/core_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1
